// ==== bench/fe_testdata.mem ====
// kind hold phase | syncError stepCount clkRunning klReset klEnabled burstCount mboxWrite
// kind 0 master, 1 soft, 2 master with a soft request while busy, ff ends the list
0 0 0  0 00 1 0 1 00 00050
0 0 1  0 03 1 0 1 00 00050
0 0 2  0 02 1 0 1 00 00050
0 0 3  0 01 1 0 1 00 00050
1 0 0  0 01 0 0 1 00 00050
0 1 2  1 04 1 0 1 00 00050
1 1 0  1 04 0 0 1 00 00050
1 0 0  1 05 0 0 1 00 00050
2 0 1  0 03 1 0 1 00 00050
0 1 0  0 00 1 0 1 00 00050
2 0 2  0 02 1 0 1 00 00050
1 0 0  0 02 0 0 1 00 00050
ff 0 0 0 00 0 0 0 00 00000

// ==== compile.f ====
design/fePkg.sv
design/diagSequencer.sv
design/ebusStrober.sv
design/clkDiagCtl.sv
design/feSubsystem.sv
bench/ebusStrober_props.sv
bench/feSubsystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=feSubsystemTb
LOG=sim.log

echo "Building $TOP"
verilator --binary --timing --assert -f compile.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

echo "Running simulation"
./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0

// ==== bench/feSubsystemTb.sv ====
// Front-end subsystem testbench
`timescale 1ns/100ps

module feSubsystemTb import fePkg::*; ();

  localparam int Fields        = 10;     // Words per test line
  localparam int MaxTests      = 32;
  localparam int DoneTimeout   = 2000;   // Cycles allowed for one sequence
  localparam int Settle        = 8;      // Quiet cycles watched after done
  localparam int MasterStrobes = 17;     // Twelve phase 1 and five phase 2 functions
  localparam int SoftStrobes   = 5;

  logic       clk;
  logic       rst;
  logic       masterResetReq;
  logic       softResetReq;
  logic       mboxHold;
  tMboxPhase  phaseInit;
  logic       busy;
  logic       done;
  logic       syncError;
  logic       clkRunning;
  logic       klReset;
  logic       runFlop;
  logic       klEnabled;
  logic [7:0] burstCount;
  tEbusRh     mboxWrite;
  logic [7:0] stepCount;
  tEbusDiag   ebus;

  logic [31:0] testMem [MaxTests*Fields];   // Replayed test lines
  logic [31:0] lfsr;
  logic        strobePrev;
  tEbusDiag    lastStrobe;                  // Bus at the latest strobe rise
  int          strobeEdges;                 // Strobe rising edges seen
  int          doneCount;
  int          errorCount;
  int          checkCount;
  int          testCount;

  feSubsystem dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus activity monitor

  always @(posedge clk) begin
    if (rst) begin
      strobePrev  <= 1'b0;
      strobeEdges <= 0;
      doneCount   <= 0;
      lastStrobe  <= '0;
    end else begin
      strobePrev <= ebus.strobe;
      if (ebus.strobe && !strobePrev) begin
        strobeEdges <= strobeEdges + 1;
        lastStrobe  <= ebus;     // Function and data as strobed
      end
      if (done) doneCount <= doneCount + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  // Galois LFSR, right shift form
  function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
  endfunction

  task automatic drawBits(input int nBits, output int value);
    value = 0;
    for (int i = 0; i < nBits; i++) begin
      value = (value << 1) | int'(lfsr[0]);   // One step per bit
      lfsr  = nextLfsr(lfsr);
    end
  endtask

  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic waitForDone(input int n, output logic timedOut);
    int cycles;
    cycles   = 0;
    timedOut = 1'b0;
    do begin
      @(negedge clk);
      cycles++;
    end while (done !== 1'b1 && cycles < DoneTimeout);
    if (done !== 1'b1) begin
      timedOut = 1'b1;
      $display("Test %0d timed out: no done pulse within %0d cycles", n, DoneTimeout);
    end
  endtask

  // Kind 0 master, 1 soft, 2 master with a soft request while busy
  task automatic runTest(input int n, output logic timedOut);
    int         base;
    logic [7:0] kind;
    int         strobesBefore;
    int         donesBefore;
    int         errorsBefore;
    int         expStrobes;
    string      kindName;
    base          = n * Fields;
    kind          = testMem[base][7:0];
    strobesBefore = strobeEdges;
    donesBefore   = doneCount;
    errorsBefore  = errorCount;
    testCount++;
    @(posedge clk);
    mboxHold  <= testMem[base+1][0];
    phaseInit <= tMboxPhase'(testMem[base+2][1:0]);
    if (kind == 8'h1) softResetReq <= 1'b1;
    else masterResetReq <= 1'b1;
    @(posedge clk);
    masterResetReq <= 1'b0;
    softResetReq   <= 1'b0;
    if (kind == 8'h2) begin
      // Soft request lands in the middle of phase 1
      repeat (3) @(negedge clk);
      checkValue("busy before soft request", 32'(busy), 32'd1);
      @(posedge clk);
      softResetReq <= 1'b1;
      @(posedge clk);
      softResetReq <= 1'b0;
    end
    waitForDone(n, timedOut);
    if (!timedOut) begin
      repeat (Settle) @(negedge clk);   // A late second start would show here
      // Strobes are the list length plus the sync loop steps
      if (kind == 8'h1) expStrobes = SoftStrobes;
      else expStrobes = MasterStrobes + int'(testMem[base+4]);
      checkValue("syncError", 32'(syncError), testMem[base+3]);
      checkValue("stepCount", 32'(stepCount), testMem[base+4]);
      checkValue("clkRunning", 32'(clkRunning), testMem[base+5]);
      checkValue("klReset", 32'(klReset), testMem[base+6]);
      checkValue("klEnabled", 32'(klEnabled), testMem[base+7]);
      checkValue("burstCount", 32'(burstCount), testMem[base+8]);
      checkValue("mboxWrite", 32'(mboxWrite), testMem[base+9]);
      checkValue("runFlop", 32'(runFlop), 32'd0);   // Cleared first by master
      checkValue("strobe count", 32'(strobeEdges - strobesBefore), 32'(expStrobes));
      // Each list ends with a known function on the bus
      if (kind == 8'h1) begin
        checkValue("last function", 32'(lastStrobe.func), 32'o007);   // Clear reset
        checkValue("last driving", 32'(lastStrobe.driving), 32'd0);
        checkValue("last data", 32'(lastStrobe.data), 32'd0);
      end else begin
        checkValue("last function", 32'(lastStrobe.func), 32'o071);   // Write MBOX
        checkValue("last driving", 32'(lastStrobe.driving), 32'd1);
        checkValue("last data", 32'(lastStrobe.data), 32'o120);
      end
      checkValue("done pulses", 32'(doneCount - donesBefore), 32'd1);
      checkValue("busy after done", 32'(busy), 32'd0);
      case (kind)
        8'h0:    kindName = "master reset";
        8'h1:    kindName = "soft reset";
        default: kindName = "master reset, soft ignored";
      endcase
      $display("Test %0d %s hold %0d phase %0d: %s", n, kindName, testMem[base+1],
               testMem[base+2], (errorCount == errorsBefore) ? "ok" : "mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int   n;
    int   gap;
    logic timedOut;
    rst            = 1'b1;
    masterResetReq = 1'b0;
    softResetReq   = 1'b0;
    mboxHold       = 1'b0;
    phaseInit      = '0;
    lfsr           = 32'd73078;
    errorCount     = 0;
    checkCount     = 0;
    testCount      = 0;
    timedOut       = 1'b0;
    n              = 0;
    $readmemh("bench/fe_testdata.mem", testMem);
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkValue("outputs after reset", 32'({busy, done, syncError, clkRunning, klReset,
               runFlop, klEnabled, ebus.strobe, ebus.driving}), 32'd0);
    while (n < MaxTests && testMem[n*Fields] != 32'hff && !timedOut) begin
      runTest(n, timedOut);
      if (!timedOut) begin
        drawBits(4, gap);                // Idle gap of 0 to 15 cycles
        repeat (gap) @(negedge clk);
      end
      n++;
    end
    $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (!timedOut && errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== bench/ebusStrober_props.sv ====
// EBUS strober timing assertions
`timescale 1ns/100ps

module ebusStroberProps import fePkg::*; (
  input logic     clk,
  input logic     rst,
  input tEbusDiag ebus,
  input logic     creditReturn,
  input tCredit   count
);

  int highCnt;   // Consecutive cycles with strobe high

  always_ff @(posedge clk) begin
    if (rst) highCnt <= 0;
    else if (ebus.strobe) highCnt <= highCnt + 1;
    else highCnt <= 0;
  end

  // Strobe never outlasts its hold time
  strobeNotLong: assert property (@(posedge clk) disable iff (rst)
    ebus.strobe |-> highCnt < StrobeHold)
    else $error("Strobe high for more than %0d cycles", StrobeHold);

  strobeNotShort: assert property (@(posedge clk) disable iff (rst)
    $fell(ebus.strobe) |-> highCnt == StrobeHold)   // Falls only after full hold
    else $error("Strobe fell after %0d cycles", highCnt);

  // Credit comes back only in the gap
  creditInGap: assert property (@(posedge clk) disable iff (rst)
    creditReturn |-> !ebus.strobe)
    else $error("Credit returned while strobe high");

  queueBound: assert property (@(posedge clk) disable iff (rst)
    int'(count) <= CmdCredits)
    else $error("Strober queue holds %0d entries", count);

endmodule

bind ebusStrober ebusStroberProps uProps (
  .clk, .rst, .ebus, .creditReturn, .count
);

// ==== design/feSubsystem.sv ====
// Front-end diagnostic subsystem
`timescale 1ns/100ps

module feSubsystem import fePkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       masterResetReq,
  input  logic       softResetReq,
  input  logic       mboxHold,
  input  tMboxPhase  phaseInit,
  output logic       busy,
  output logic       done,
  output logic       syncError,
  output logic       clkRunning,
  output logic       klReset,
  output logic       runFlop,
  output logic       klEnabled,
  output logic [7:0] burstCount,
  output tEbusRh     mboxWrite,
  output logic [7:0] stepCount,
  output tEbusDiag   ebus
);

  tDiagCmd cmd;
  logic    cmdValid;
  logic    creditReturn;
  logic    aChangeComing;
  logic    startMaster;    // Accepted master request, loads MBOX phase

  diagSequencer uSeq (
    .clk, .rst, .masterResetReq, .softResetReq, .aChangeComing, .creditReturn,
    .cmd, .cmdValid, .busy, .done, .syncError, .startMaster
  );

  ebusStrober uStrober (
    .clk, .rst, .cmd, .cmdValid, .creditReturn, .ebus
  );

  clkDiagCtl uClk (
    .clk, .rst, .ebus, .phaseLoad(startMaster), .phaseInit, .mboxHold,
    .aChangeComing, .clkRunning, .klReset, .runFlop, .klEnabled,
    .burstCount, .mboxWrite, .stepCount
  );

endmodule

// ==== design/clkDiagCtl.sv ====
// CLK module diagnostic decoder
`timescale 1ns/100ps

module clkDiagCtl import fePkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  tEbusDiag   ebus,
  input  logic       phaseLoad,
  input  tMboxPhase  phaseInit,
  input  logic       mboxHold,
  output logic       aChangeComing,
  output logic       clkRunning,
  output logic       klReset,
  output logic       runFlop,
  output logic       klEnabled,
  output logic [7:0] burstCount,
  output tEbusRh     mboxWrite,
  output logic [7:0] stepCount
);

  logic      strobeLast;   // Strobe one cycle ago
  logic      strobeEdge;
  logic      stepHit;
  tEbusRh    dataRh;       // Right half as seen by the CLK module
  tMboxPhase phase;
  logic      klEnable;     // KL decoding enable flop
  logic [3:0] eboxClkDis;  // EBOX clock disables

  ////////////////////////////////////////////////////////////////////////////
  // Strobe edge and operand

  always_ff @(posedge clk) begin
    if (rst) strobeLast <= 1'b0;
    else strobeLast <= ebus.strobe;
  end

  assign strobeEdge = ebus.strobe && !strobeLast;   // Act once per strobe
  assign dataRh     = ebus.driving ? ebus.data : '0; // Undriven bus reads zero

  // MBOX is mid-cycle whenever its phase is not zero
  assign aChangeComing = (phase != '0);

  // Conditional step only moves a free MBOX that is mid-cycle
  assign stepHit = (ebus.func == diagStepClock) ||
                   ((ebus.func == diagCondStep) && aChangeComing && !mboxHold);

  // Any EBOX clock disable blocks KL decoding
  assign klEnabled = klEnable && (eboxClkDis == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Control flops

  always_ff @(posedge clk) begin
    if (rst) begin
      runFlop    <= 1'b0;
      clkRunning <= 1'b0;
      klReset    <= 1'b0;
      klEnable   <= 1'b0;
      eboxClkDis <= '0;
      burstCount <= '0;
    end else if (strobeEdge) begin
      case (ebus.func)
        diagClrRun:     runFlop    <= 1'b0;
        diagSetRun:     runFlop    <= 1'b1;
        diagStartClock: clkRunning <= 1'b1;
        diagStopClock:  clkRunning <= 1'b0;
        diagSetReset:   klReset    <= 1'b1;
        diagClrReset:   klReset    <= 1'b0;
        diagBurstRh:    burstCount[3:0] <= dataRh[3:0];   // Low nibble
        diagBurstLh:    burstCount[7:4] <= dataRh[3:0];   // High nibble
        diagEboxClkDis: eboxClkDis <= dataRh[3:0];
        diagEnableKl:   klEnable   <= 1'b1;
        default: begin
          // Other functions have no state in this model
        end
      endcase
    end
  end

  // MBOX write register
  always_ff @(posedge clk) begin
    if (strobeEdge && (ebus.func == diagWriteMbox)) mboxWrite <= dataRh;
  end

  ////////////////////////////////////////////////////////////////////////////
  // MBOX phase and step count

  always_ff @(posedge clk) begin
    if (rst) begin
      phase     <= '0;
      stepCount <= '0;
    end else if (phaseLoad) begin
      phase     <= phaseInit;    // Start of a master reset
      stepCount <= '0;
    end else if (strobeEdge && stepHit) begin
      if (!mboxHold) phase <= phase + 1'b1;   // Wraps after four steps
      stepCount <= stepCount + 1'b1;          // Counts held steps too
    end
  end

endmodule

// ==== design/ebusStrober.sv ====
// EBUS diagnostic strobe generator
`timescale 1ns/100ps

module ebusStrober import fePkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  tDiagCmd  cmd,
  input  logic     cmdValid,
  output logic     creditReturn,
  output tEbusDiag ebus
);

  tDiagCmd   queue [CmdCredits];   // Command storage
  logic      wrPtr;
  logic      rdPtr;
  tCredit    count;                // Entries held
  tStrobeCnt timer;                // Cycles since strobe rose
  logic      active;               // A strobe or its gap is in progress
  logic      strobeEnd;
  logic      lastGap;
  logic      push;
  logic      pop;
  tDiagCmd   head;

  ////////////////////////////////////////////////////////////////////////////
  // Command queue

  assign push = cmdValid;           // Credits guarantee room

  // Empty queue passes the incoming command straight through
  assign head = (count == '0) ? cmd : queue[rdPtr];

  always_ff @(posedge clk) begin
    if (push) queue[wrPtr] <= cmd;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      count <= '0;
    end else begin
      if (push) wrPtr <= ~wrPtr;    // Two entries, pointer toggles
      if (pop)  rdPtr <= ~rdPtr;
      count <= count + tCredit'(push) - tCredit'(pop);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobe shaping

  assign strobeEnd = (timer == tStrobeCnt'(StrobeHold - 1));               // Last high cycle
  assign lastGap   = active && (timer == tStrobeCnt'(StrobeHold + StrobeGap - 1));

  // Start the next strobe right after the gap
  assign pop = (!active || lastGap) && ((count != '0) || cmdValid);

  assign creditReturn = lastGap;    // Slot free again

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      timer  <= '0;
      ebus   <= '0;
    end else if (pop) begin
      active       <= 1'b1;
      timer        <= '0;
      ebus.strobe  <= 1'b1;
      ebus.func    <= head.func;
      ebus.data    <= head.isWrite ? head.data : '0;   // Bus idles at zero
      ebus.driving <= head.isWrite;
    end else if (active) begin
      timer <= timer + 1'b1;
      if (lastGap) active <= 1'b0;
      if (strobeEnd) begin
        // Drop strobe and release the data lines together
        ebus.strobe  <= 1'b0;
        ebus.driving <= 1'b0;
        ebus.data    <= '0;
      end
    end
  end

endmodule

// ==== design/diagSequencer.sv ====
// Reset sequence controller
`timescale 1ns/100ps

module diagSequencer import fePkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    masterResetReq,
  input  logic    softResetReq,
  input  logic    aChangeComing,
  input  logic    creditReturn,
  output tDiagCmd cmd,
  output logic    cmdValid,
  output logic    busy,
  output logic    done,
  output logic    syncError,
  output logic    startMaster
);

  typedef enum logic [2:0] {
    sIdle, sPhase1, sDrain, sSyncWait, sPhase2, sSoft, sFinish
  } tSeqState;

  tSeqState   state;
  tListIdx    idx;           // Next entry of the active list
  tCredit     credits;       // Free strober slots
  logic [2:0] waitCnt;       // Settle timer for the sync sample
  logic [2:0] tries;         // Samples taken so far
  logic       startSoft;
  logic       listState;
  logic       listLast;
  logic       creditsFull;
  logic       sampleNow;
  logic       stepNow;

  ////////////////////////////////////////////////////////////////////////////
  // Function lists

  // Master reset, phase 1
  function automatic tDiagCmd phase1Cmd(input tListIdx i);
    case (i)
      4'd0:    return tDiagCmd'{diagClrRun,        '0, 1'b0};
      4'd1:    return tDiagCmd'{diagClkSrcRate,    '0, 1'b1};
      4'd2:    return tDiagCmd'{diagStopClock,     '0, 1'b0};
      4'd3:    return tDiagCmd'{diagSetReset,      '0, 1'b0};
      4'd4:    return tDiagCmd'{diagResetParRegs,  '0, 1'b1};
      4'd5:    return tDiagCmd'{diagMboxDisParChk, '0, 1'b1};
      4'd6:    return tDiagCmd'{diagBurstRh,       '0, 1'b1};
      4'd7:    return tDiagCmd'{diagBurstLh,       '0, 1'b1};
      4'd8:    return tDiagCmd'{diagEboxClkDis,    '0, 1'b1};
      4'd9:    return tDiagCmd'{diagStartClock,    '0, 1'b0};
      4'd10:   return tDiagCmd'{diagInitChannels,  '0, 1'b1};
      default: return tDiagCmd'{diagBurstRh,       '0, 1'b1};
    endcase
  endfunction

  // Master reset, phase 2 after MBOX sync
  function automatic tDiagCmd phase2Cmd(input tListIdx i);
    case (i)
      4'd0:    return tDiagCmd'{diagCondStep, '0, 1'b0};
      4'd1:    return tDiagCmd'{diagClrReset, '0, 1'b0};
      4'd2:    return tDiagCmd'{diagEnableKl, '0, 1'b1};
      4'd3:    return tDiagCmd'{diagEbusLoad, '0, 1'b1};
      default: return tDiagCmd'{diagWriteMbox, MboxInitData, 1'b1};
    endcase
  endfunction

  // Soft reset for RAM loaders
  function automatic tDiagCmd softCmd(input tListIdx i);
    case (i)
      4'd0:    return tDiagCmd'{diagSetReset,   '0, 1'b0};
      4'd1:    return tDiagCmd'{diagStartClock, '0, 1'b0};
      4'd2:    return tDiagCmd'{diagStopClock,  '0, 1'b0};
      4'd3:    return tDiagCmd'{diagCondStep,   '0, 1'b0};
      default: return tDiagCmd'{diagClrReset,   '0, 1'b0};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Issue logic

  assign startMaster = (state == sIdle) && masterResetReq;   // Master wins a tie
  assign startSoft   = (state == sIdle) && softResetReq && !masterResetReq;
  assign busy        = (state != sIdle);
  assign creditsFull = (credits == tCredit'(CmdCredits));    // Strober fully drained
  assign listState   = (state == sPhase1) || (state == sPhase2) || (state == sSoft);

  // Sample A change coming once the settle time is over
  assign sampleNow = (state == sSyncWait) && (waitCnt == 3'(SyncWait - 1));
  assign stepNow   = sampleNow && aChangeComing && (tries != 3'(SyncTries - 1));

  always_comb begin
    case (state)
      sPhase1: listLast = (idx == tListIdx'(Phase1Len - 1));
      sPhase2: listLast = (idx == tListIdx'(Phase2Len - 1));
      default: listLast = (idx == tListIdx'(SoftLen - 1));
    endcase
  end

  always_comb begin
    case (state)
      sPhase1:   cmd = phase1Cmd(idx);
      sPhase2:   cmd = phase2Cmd(idx);
      sSoft:     cmd = softCmd(idx);
      sSyncWait: cmd = tDiagCmd'{diagStepClock, '0, 1'b0};   // Sync loop step
      default:   cmd = '0;
    endcase
  end

  // Hold the command while out of credits
  assign cmdValid = (listState && (credits != '0)) || stepNow;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer FSM

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= sIdle;
      idx       <= '0;
      credits   <= tCredit'(CmdCredits);
      waitCnt   <= '0;
      tries     <= '0;
      done      <= 1'b0;
      syncError <= 1'b0;
    end else begin
      credits <= credits - tCredit'(cmdValid) + tCredit'(creditReturn);
      done    <= 1'b0;
      case (state)
        sIdle: begin
          idx <= '0;
          if (startMaster) begin
            syncError <= 1'b0;          // New master reset, fresh status
            state     <= sPhase1;
          end else if (startSoft) begin
            state <= sSoft;
          end
        end
        sPhase1: begin
          if (cmdValid) begin
            if (listLast) begin
              idx   <= '0;
              tries <= '0;
              state <= sDrain;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        sDrain: begin
          // Every issued function has reached the CLK module
          if (creditsFull) begin
            waitCnt <= '0;
            state   <= sSyncWait;
          end
        end
        sSyncWait: begin
          waitCnt <= waitCnt + 1'b1;
          if (sampleNow) begin
            if (stepNow) begin
              tries <= tries + 1'b1;
              state <= sDrain;
            end else begin
              if (aChangeComing) syncError <= 1'b1;   // MBOX never synced
              state <= sPhase2;
            end
          end
        end
        sPhase2, sSoft: begin
          if (cmdValid) begin
            if (listLast) state <= sFinish;
            else idx <= idx + 1'b1;
          end
        end
        default: begin
          // Finish once the last strobe is out
          if (creditsFull) begin
            done  <= 1'b1;
            state <= sIdle;
          end
        end
      endcase
    end
  end

endmodule

// ==== design/fePkg.sv ====
// Front-end diagnostic definitions
package fePkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths that carry a meaning

  typedef logic [6:0]  tDiagFunc;   // CLK diagnostic function code
  typedef logic [17:0] tEbusRh;     // EBUS right half, bits 18..35
  typedef logic [1:0]  tMboxPhase;  // MBOX four-phase counter
  typedef logic [1:0]  tCredit;     // Credit count and queue fill level
  typedef logic [3:0]  tListIdx;    // Position within a function list
  typedef logic [3:0]  tStrobeCnt;  // Strobe hold plus gap timer

  ////////////////////////////////////////////////////////////////////////////
  // Diagnostic function codes seen by the CLK module

  localparam tDiagFunc diagStopClock     = 7'o000;
  localparam tDiagFunc diagStartClock    = 7'o001;
  localparam tDiagFunc diagStepClock     = 7'o002;  // Single step MBOX
  localparam tDiagFunc diagCondStep      = 7'o004;  // Step only if mid-cycle
  localparam tDiagFunc diagSetReset      = 7'o006;
  localparam tDiagFunc diagClrReset      = 7'o007;
  localparam tDiagFunc diagClrRun        = 7'o010;
  localparam tDiagFunc diagSetRun        = 7'o011;
  localparam tDiagFunc diagBurstRh       = 7'o042;  // Burst counter 8,4,2,1
  localparam tDiagFunc diagBurstLh       = 7'o043;  // Burst counter 128,64,32,16
  localparam tDiagFunc diagClkSrcRate    = 7'o044;
  localparam tDiagFunc diagMboxDisParChk = 7'o045;
  localparam tDiagFunc diagResetParRegs  = 7'o046;
  localparam tDiagFunc diagEboxClkDis    = 7'o047;
  localparam tDiagFunc diagEnableKl      = 7'o067;
  localparam tDiagFunc diagInitChannels  = 7'o070;
  localparam tDiagFunc diagWriteMbox     = 7'o071;
  localparam tDiagFunc diagEbusLoad      = 7'o076;  // Sets memory reset flop

  localparam tEbusRh MboxInitData = 18'o000120;     // Written by last master step

  ////////////////////////////////////////////////////////////////////////////
  // Flow control and timing

  localparam int CmdCredits = 2;   // Strober queue depth
  localparam int StrobeHold = 9;   // Cycles with strobe high
  localparam int StrobeGap  = 4;   // Idle cycles before a credit returns
  localparam int SyncTries  = 5;   // Max samples of A change coming
  localparam int SyncWait   = 5;   // Settle cycles before each sample

  // Function list lengths
  localparam int Phase1Len = 12;
  localparam int Phase2Len = 5;
  localparam int SoftLen   = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles

  // One command from the sequencer
  typedef struct packed {
    tDiagFunc func;
    tEbusRh   data;
    logic     isWrite;   // Data goes on the bus
  } tDiagCmd;

  // Diagnostic side of the EBUS
  typedef struct packed {
    logic     strobe;    // Diag strobe
    tDiagFunc func;      // DS lines
    tEbusRh   data;      // Right half data
    logic     driving;   // Data valid
  } tEbusDiag;

endpackage
